// File: src.f
logic/ppu_pkg.sv
logic/frame_timing.sv
logic/scroll_addr.sv
logic/bg_shifter.sv
logic/palette_ram.sv
logic/ppu_ctrl.sv
logic/ppu_top.sv
bench/ppu_checker.sv
bench/ppu_tb.sv

// File: run.sh
#!/bin/sh
# Build the PPU testbench with Verilator, run it and look for the pass message
verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module ppu_tb \
  -Mdir obj_dir -o ppu_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/ppu_sim)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

// File: bench/ppu_tb.sv
// ******************************
// PPU background testbench
// Clock, reset, VRAM model and register table
// ******************************
module ppu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] OP_WRITE  = 2'd0;
  localparam logic [1:0] OP_READ   = 2'd1;
  localparam logic [1:0] OP_VBLANK = 2'd2; // Wait for nmi

  typedef struct packed {
    logic [1:0]  op;
    logic [2:0]  ain;
    logic [7:0]  din;
    logic [15:0] exp; // Read data, or VRAM address of a data write
    logic        chk;
  } row_t;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic                read = 1'b0;
  logic                write = 1'b0;
  ppu_pkg::reg_addr_t  ain = '0;
  ppu_pkg::byte_t      din = '0;
  ppu_pkg::byte_t      vram_din = '0;
  ppu_pkg::byte_t      dout, vram_dout;
  ppu_pkg::color_t     color;
  logic                nmi, vram_r, vram_w;
  ppu_pkg::vram_addr_t vram_a;
  ppu_pkg::cycle_t     scanline, cycle;

  row_t            rows[$];
  ppu_pkg::color_t pal_model [32];   // Expected palette contents
  logic [31:0]     lcg_state = 32'd54613;
  int              num_rows = 0;
  logic [15:0]     exp_data = '0;
  logic            exp_chk = 1'b0;
  logic            color_en = 1'b0;
  ppu_pkg::color_t exp_color = '0;
  int              errors, checks;

  always #4 clk = ~clk; // 8 ns period

  ppu_top dut (
    .clk, .reset, .read, .write, .ain, .din, .dout, .color, .nmi,
    .vram_r, .vram_w, .vram_a, .vram_din, .vram_dout, .scanline, .cycle
  );

  ppu_checker u_checker (
    .clk, .reset, .read, .write, .ain, .din, .dout, .nmi, .vram_r, .vram_w, .vram_a,
    .vram_dout, .color, .scanline, .cycle, .exp_data, .exp_chk, .color_en,
    .exp_color, .errors, .checks
  );

  // Nametables and pattern table 1 read as zero and other addresses as their low byte
  function automatic ppu_pkg::byte_t vram_data(input ppu_pkg::vram_addr_t a);
    if (a >= 14'h1000 && a <= 14'h2FFF)
      return 8'h00;
    return a[7:0];
  endfunction

  // Synchronous VRAM, data one cycle after the strobe
  always @(posedge clk) begin
    if (vram_r)
      vram_din <= vram_data(vram_a);
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Colour 0 of every group shows the backdrop
  function automatic ppu_pkg::pal_addr_t pal_entry(input ppu_pkg::pal_addr_t a);
    return (a[1:0] == 2'b00) ? 5'd0 : a;
  endfunction

  task automatic add_row(input logic [1:0] op, input ppu_pkg::reg_addr_t ain_v,
                         input ppu_pkg::byte_t din_v, input logic [15:0] exp_v,
                         input logic chk_v);
    rows.push_back(row_t'{op, ain_v, din_v, exp_v, chk_v});
  endtask

  task automatic set_vram_addr(input ppu_pkg::vram_addr_t a);
    add_row(OP_WRITE, ppu_pkg::REG_ADDR, {2'b00, a[13:8]}, 16'h0000, 1'b0); // High byte first
    add_row(OP_WRITE, ppu_pkg::REG_ADDR, a[7:0], 16'h0000, 1'b0);
  endtask

  task automatic build_table();
    ppu_pkg::color_t    val;
    ppu_pkg::pal_addr_t idx;
    for (int i = 0; i < 32; i++)
      pal_model[i] = '0; // Cleared by reset
    // Vblank with nmi enabled and the flag cleared by one status read
    add_row(OP_WRITE, ppu_pkg::REG_CTRL, 8'h80, 16'h0000, 1'b0);
    add_row(OP_VBLANK, 3'd0, 8'h00, 16'h0000, 1'b0);
    add_row(OP_READ, ppu_pkg::REG_STATUS, 8'h00, 16'h0080, 1'b1);
    add_row(OP_READ, ppu_pkg::REG_STATUS, 8'h00, 16'h0000, 1'b1);
    set_vram_addr(14'h2108);
    for (int i = 0; i < 3; i++)
      add_row(OP_WRITE, ppu_pkg::REG_DATA, 8'hA0 + 8'(i), 16'h2108 + 16'(i), 1'b1);
    add_row(OP_WRITE, ppu_pkg::REG_CTRL, 8'h84, 16'h0000, 1'b0); // Step of 32
    set_vram_addr(14'h2108);
    for (int i = 0; i < 3; i++)
      add_row(OP_WRITE, ppu_pkg::REG_DATA, 8'hB0 + 8'(i), 16'h2108 + 16'(32 * i), 1'b1);
    // Buffered reads with the buffer primed from 0x0133
    add_row(OP_WRITE, ppu_pkg::REG_CTRL, 8'h00, 16'h0000, 1'b0);
    set_vram_addr(14'h0133);
    add_row(OP_READ, ppu_pkg::REG_DATA, 8'h00, 16'h0000, 1'b0);
    set_vram_addr(14'h0155);
    add_row(OP_READ, ppu_pkg::REG_DATA, 8'h00, 16'h0033, 1'b1);
    add_row(OP_READ, ppu_pkg::REG_DATA, 8'h00, 16'h0055, 1'b1);
    set_vram_addr(14'h3F00);
    for (int i = 0; i < 32; i++) begin
      lcg_state = lcg_next(lcg_state);
      val       = lcg_state[21:16];
      idx       = 5'(i);
      add_row(OP_WRITE, ppu_pkg::REG_DATA, {2'b00, val}, 16'h0000, 1'b0); // No vram_w
      if (!(idx[3:2] != 2'b00 && idx[1:0] == 2'b00))
        pal_model[pal_entry(idx)] = val; // 0x04, 0x08, 0x0C ignored
    end
    set_vram_addr(14'h3F00);
    for (int i = 0; i < 32; i++)
      add_row(OP_READ, ppu_pkg::REG_DATA, 8'h00, {10'd0, pal_model[pal_entry(5'(i))]}, 1'b1);
    // Render from pattern table 1, then again in grayscale
    add_row(OP_WRITE, ppu_pkg::REG_CTRL, 8'h90, 16'h0000, 1'b0);
    add_row(OP_WRITE, ppu_pkg::REG_MASK, 8'h0A, 16'h0000, 1'b0);
    add_row(OP_VBLANK, 3'd0, 8'h00, 16'h0000, 1'b0);
    add_row(OP_READ, ppu_pkg::REG_STATUS, 8'h00, 16'h0080, 1'b1);
    add_row(OP_WRITE, ppu_pkg::REG_MASK, 8'h0B, 16'h0000, 1'b0);
    add_row(OP_VBLANK, 3'd0, 8'h00, 16'h0000, 1'b0);
    add_row(OP_READ, ppu_pkg::REG_STATUS, 8'h00, 16'h0080, 1'b1);
  endtask

  task automatic apply_row(input row_t r);
    if (r.op == OP_VBLANK) begin
      @(negedge clk);
      while (!nmi)
        @(negedge clk);
    end else begin
      @(posedge clk);
      #1;
      ain      = r.ain;
      din      = r.din;
      read     = r.op == OP_READ;
      write    = r.op == OP_WRITE;
      exp_data = r.exp;
      exp_chk  = r.chk;
      @(posedge clk);
      #1;
      read    = 1'b0;
      write   = 1'b0;
      exp_chk = 1'b0;
      if (r.op == OP_WRITE && r.ain == ppu_pkg::REG_MASK) begin
        color_en  = r.din[3]; // Playfield on
        exp_color = r.din[0] ? {pal_model[0][5:4], 4'h0} : pal_model[0];
      end
    end
  endtask

  initial begin
    build_table();
    num_rows = rows.size();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (rows[i])
      apply_row(rows[i]);
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // Three frames of cycles plus a few per row
  initial begin
    wait (num_rows > 0);
    #((3 * 262 * 341 + 4 * num_rows + 16) * 8);
    $display("Timeout: table did not complete, nmi never arrived or a wait hung");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: bench/ppu_checker.sv
// ******************************
// PPU testbench monitor
// Compares reads, VRAM writes, nmi and colour
// ******************************
module ppu_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                read,
  input  logic                write,
  input  ppu_pkg::reg_addr_t  ain,
  input  ppu_pkg::byte_t      din,
  input  ppu_pkg::byte_t      dout,
  input  logic                nmi,
  input  logic                vram_r,
  input  logic                vram_w,
  input  ppu_pkg::vram_addr_t vram_a,
  input  ppu_pkg::byte_t      vram_dout,
  input  ppu_pkg::color_t     color,
  input  ppu_pkg::cycle_t     scanline,
  input  ppu_pkg::cycle_t     cycle,
  input  logic [15:0]         exp_data,  // Read data or VRAM write address
  input  logic                exp_chk,
  input  logic                color_en,  // Backdrop check on visible pixels
  input  ppu_pkg::color_t     exp_color,
  output int                  errors,
  output int                  checks
);
  timeunit 1ns;
  timeprecision 1ps;

  logic status_read_q; // Status was read last cycle
  logic nmi_q;         // nmi one cycle ago

  task automatic compare(input string name, input logic [15:0] got,
                         input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      if (errors <= 20)
        $display("[ERROR] %0t %s: got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  initial begin
    errors        = 0;
    checks        = 0;
    status_read_q = 1'b0;
    nmi_q         = 1'b0;
  end

  // Inputs settle 1 ns after the rising edge, so the falling edge is quiet
  always @(negedge clk) begin
    if (!reset) begin
      if (status_read_q)
        compare("nmi", {15'd0, nmi}, 16'h0000); // Flag cleared by the read
      // Vblank flag rises as the line after the post-render line starts
      if (nmi && !nmi_q) begin
        compare("scanline", {7'd0, scanline}, {7'd0, ppu_pkg::POST_LINE + 9'd1});
        compare("cycle", {7'd0, cycle}, 16'h0000);
      end
      if (write && ain == ppu_pkg::REG_DATA) begin
        compare("vram_w", {15'd0, vram_w}, {15'd0, exp_chk});
        if (exp_chk) begin
          compare("vram_a", {2'b00, vram_a}, exp_data);
          compare("vram_dout", {8'h00, vram_dout}, {8'h00, din});
        end
      end
      if (read && ain == ppu_pkg::REG_DATA)
        compare("vram_r", {15'd0, vram_r}, 16'h0001); // Data read strobes VRAM
      if (read && exp_chk)
        compare("dout", {8'h00, dout}, exp_data);
      // Lines 0..239, cycles 0..255
      if (color_en && scanline <= 9'd239 && cycle < 9'd256)
        compare("color", {10'd0, color}, {10'd0, exp_color});
      status_read_q = read && ain == ppu_pkg::REG_STATUS;
      nmi_q         = nmi;
    end
  end

endmodule

// File: logic/ppu_top.sv
// ******************************
// PPU background top level
// ******************************
module ppu_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                read,
  input  logic                write,
  input  ppu_pkg::reg_addr_t  ain,
  input  ppu_pkg::byte_t      din,
  output ppu_pkg::byte_t      dout,
  output ppu_pkg::color_t     color,
  output logic                nmi,
  output logic                vram_r,
  output logic                vram_w,
  output ppu_pkg::vram_addr_t vram_a,
  input  ppu_pkg::byte_t      vram_din,
  output ppu_pkg::byte_t      vram_dout,
  output ppu_pkg::cycle_t     scanline,
  output ppu_pkg::cycle_t     cycle
);

  logic rendering, in_vblank, pre_render, end_of_line, last_group;
  logic entering_vblank, exiting_vblank;
  logic addr_inc32, pal_we;

  ppu_pkg::scroll_t   vaddr;
  ppu_pkg::fine_x_t   fine_x;
  ppu_pkg::byte_t     name_byte;
  logic [3:0]         pixel;
  ppu_pkg::pal_addr_t pal_addr;
  ppu_pkg::color_t    pal_wdata, pal_rdata;

  frame_timing u_timing (
    .clk, .reset, .rendering, .cycle, .scanline, .in_vblank, .pre_render,
    .end_of_line, .last_group, .entering_vblank, .exiting_vblank
  );

  scroll_addr u_scroll (
    .clk, .reset, .rendering, .pre_render, .cycle, .ain, .din, .read, .write,
    .addr_inc32, .vaddr, .fine_x
  );

  // Pipes hold still over the last cycle group
  bg_shifter u_bg (
    .clk, .reset, .shift(!last_group), .cycle, .fine_x, .vaddr, .vram_din,
    .name_byte, .pixel
  );

  palette_ram u_palette (
    .clk, .reset, .addr(pal_addr), .wdata(pal_wdata), .we(pal_we), .rdata(pal_rdata)
  );

  ppu_ctrl u_ctrl (
    .clk, .reset, .read, .write, .ain, .din, .dout, .cycle, .scanline, .in_vblank,
    .end_of_line, .entering_vblank, .exiting_vblank, .vaddr, .pixel, .name_byte,
    .pal_rdata, .rendering, .addr_inc32, .bg_patt(), .pal_addr, .pal_we, .pal_wdata,
    .color, .nmi, .vram_r, .vram_w, .vram_a, .vram_din, .vram_dout
  );

endmodule

// File: logic/ppu_ctrl.sv
// ******************************
// PPU control
// CPU registers, status, NMI, VRAM bus and colour out
// ******************************
module ppu_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                read,
  input  logic                write,
  input  ppu_pkg::reg_addr_t  ain,
  input  ppu_pkg::byte_t      din,
  output ppu_pkg::byte_t      dout,
  input  ppu_pkg::cycle_t     cycle,
  input  ppu_pkg::cycle_t     scanline,
  input  logic                in_vblank,
  input  logic                end_of_line,
  input  logic                entering_vblank,
  input  logic                exiting_vblank,
  input  ppu_pkg::scroll_t    vaddr,
  input  logic [3:0]          pixel,
  input  ppu_pkg::byte_t      name_byte,
  input  ppu_pkg::color_t     pal_rdata,
  output logic                rendering,
  output logic                addr_inc32,
  output logic                bg_patt,
  output ppu_pkg::pal_addr_t  pal_addr,
  output logic                pal_we,
  output ppu_pkg::color_t     pal_wdata,
  output ppu_pkg::color_t     color,
  output logic                nmi,
  output logic                vram_r,
  output logic                vram_w,
  output ppu_pkg::vram_addr_t vram_a,
  input  ppu_pkg::byte_t      vram_din,
  output ppu_pkg::byte_t      vram_dout
);

  logic vbl_enable;       // Control bit 7
  logic grayscale;        // Mask bit 0
  logic bg_clip;          // Mask bit 1, show left column
  logic enable_playfield; // Mask bit 3
  logic vbl_occurred;     // Cleared by status read
  logic read_pending;
  ppu_pkg::byte_t read_buf;

  logic       is_pal;   // Address points into palette space
  logic       data_wr;
  logic       visible;
  logic       show_bg;
  logic [3:0] bg_pixel;

  assign rendering = enable_playfield && !in_vblank && scanline != ppu_pkg::POST_LINE;
  assign is_pal    = vaddr[13:8] == 6'h3F;
  assign data_wr   = write && ain == ppu_pkg::REG_DATA;

  always_ff @(posedge clk) begin
    if (reset) begin
      vbl_enable       <= 1'b0;
      bg_patt          <= 1'b0;
      addr_inc32       <= 1'b0;
      grayscale        <= 1'b0;
      bg_clip          <= 1'b0;
      enable_playfield <= 1'b0;
      vbl_occurred     <= 1'b0;
      read_pending     <= 1'b0;
    end else begin
      if (write && ain == ppu_pkg::REG_CTRL) begin
        addr_inc32 <= din[2];
        bg_patt    <= din[4];
        vbl_enable <= din[7];
      end
      if (write && ain == ppu_pkg::REG_MASK) begin
        grayscale        <= din[0];
        bg_clip          <= din[1];
        enable_playfield <= din[3];
      end
      if (entering_vblank)
        vbl_occurred <= 1'b1;
      else if (exiting_vblank || (read && ain == ppu_pkg::REG_STATUS))
        vbl_occurred <= 1'b0;
      read_pending <= vram_r; // Data arrives one cycle after the strobe
    end
  end

  always_ff @(posedge clk) begin
    if (read_pending)
      read_buf <= vram_din;
  end

  assign nmi = vbl_occurred && vbl_enable;

  // Fetch phase picks nametable, attribute or pattern address
  always_comb begin
    if (!rendering)
      vram_a = vaddr[13:0];
    else if (cycle[2:1] == 2'd0)
      vram_a = {2'b10, vaddr[11:0]};
    else if (cycle[2:1] == 2'd1)
      vram_a = {2'b10, vaddr[11:10], 4'b1111, vaddr[9:7], vaddr[4:2]};
    else
      vram_a = {1'b0, bg_patt, name_byte, cycle[1], vaddr[14:12]}; // Planes 0 and 1
  end

  assign vram_r = (read && ain == ppu_pkg::REG_DATA) ||
                  (rendering && !cycle[0] && !end_of_line);
  assign vram_w    = data_wr && !is_pal && !rendering;
  assign vram_dout = din;

  // Left 8 pixels blanked unless clip bit set
  assign visible  = scanline <= ppu_pkg::LAST_VISIBLE_LINE && cycle < ppu_pkg::HRELOAD_CYCLE;
  assign show_bg  = visible && (bg_clip || cycle[7:3] != 5'd0);
  assign bg_pixel = {pixel[3:2], show_bg ? pixel[1:0] : 2'b00};

  always_comb begin
    if (rendering)
      pal_addr = {1'b0, bg_pixel};
    else if (is_pal)
      pal_addr = vaddr[4:0];
    else
      pal_addr = '0;
  end

  assign pal_we    = data_wr && is_pal;
  assign pal_wdata = din[5:0];
  assign color     = grayscale ? {pal_rdata[5:4], 4'b0000} : pal_rdata;

  always_comb begin
    if (ain == ppu_pkg::REG_STATUS)
      dout = {vbl_occurred, 7'b0000000};
    else if (is_pal)
      dout = {2'b00, color}; // Palette reads bypass the buffer
    else
      dout = read_buf;
  end

endmodule

// File: logic/palette_ram.sv
// ******************************
// Palette RAM
// 32 x 6 colour table, backdrop mirrored
// ******************************
module palette_ram (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::pal_addr_t addr,
  input  ppu_pkg::color_t    wdata,
  input  logic               we,
  output ppu_pkg::color_t    rdata
);

  ppu_pkg::color_t    mem [32];
  ppu_pkg::pal_addr_t entry;

  assign entry = addr[1:0] == 2'b00 ? '0 : addr; // Every colour 0 is the backdrop
  assign rdata = mem[entry];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        mem[i] <= '0;
    end else if (we && !(addr[3:2] != 2'b00 && addr[1:0] == 2'b00)) begin
      mem[entry] <= wdata; // 0x10 lands on entry 0
    end
  end

endmodule

// File: logic/bg_shifter.sv
// ******************************
// Background painter
// Fetch latches and pattern/attribute shift pipes
// ******************************
module bg_shifter (
  input  logic             clk,
  input  logic             reset,
  input  logic             shift,
  input  ppu_pkg::cycle_t  cycle,
  input  ppu_pkg::fine_x_t fine_x,
  input  ppu_pkg::scroll_t vaddr,
  input  ppu_pkg::byte_t   vram_din,
  output ppu_pkg::byte_t   name_byte,
  output logic [3:0]       pixel
);

  logic [15:0]    patt_lo, patt_hi; // Pattern plane pipes
  logic [8:0]     attr_lo, attr_hi; // Attribute bit pipes
  ppu_pkg::byte_t name_q;
  logic [1:0]     attr_q;           // Quadrant bits of current tile
  ppu_pkg::byte_t plane0;

  always_ff @(posedge clk) begin
    if (reset) begin
      name_q  <= '0;
      attr_q  <= '0;
      plane0  <= '0;
      patt_lo <= '0;
      patt_hi <= '0;
      attr_lo <= '0;
      attr_hi <= '0;
    end else begin
      case (cycle[2:0])
        3'd1: name_q <= vram_din;
        3'd3: begin
          // Coarse Y bit 1 and coarse X bit 1 pick the quadrant
          case ({vaddr[6], vaddr[1]})
            2'b00:   attr_q <= vram_din[1:0];
            2'b01:   attr_q <= vram_din[3:2];
            2'b10:   attr_q <= vram_din[5:4];
            default: attr_q <= vram_din[7:6];
          endcase
        end
        3'd5: plane0 <= vram_din;
        default: ;
      endcase
      if (shift) begin
        patt_lo <= patt_lo >> 1;
        patt_hi <= patt_hi >> 1;
        attr_lo <= {attr_lo[8], attr_lo[8:1]}; // Top bit refills all 8 pixels of a tile
        attr_hi <= {attr_hi[8], attr_hi[8:1]};
        if (cycle[2:0] == 3'd7) begin // Plane 1 is on the bus now
          patt_lo[15:8] <= {<<{plane0}};
          patt_hi[15:8] <= {<<{vram_din}};
          attr_lo[8]    <= attr_q[0];
          attr_hi[8]    <= attr_q[1];
        end
      end
    end
  end

  assign name_byte = name_q;
  assign pixel = {attr_hi[fine_x], attr_lo[fine_x], patt_hi[fine_x], patt_lo[fine_x]};

endmodule

// File: logic/scroll_addr.sv
// ******************************
// Scroll address register
// Current and temporary address, fine X and write toggle
// ******************************
module scroll_addr (
  input  logic               clk,
  input  logic               reset,
  input  logic               rendering,
  input  logic               pre_render,
  input  ppu_pkg::cycle_t    cycle,
  input  ppu_pkg::reg_addr_t ain,
  input  ppu_pkg::byte_t     din,
  input  logic               read,
  input  logic               write,
  input  logic               addr_inc32,
  output ppu_pkg::scroll_t   vaddr,
  output ppu_pkg::fine_x_t   fine_x
);

  ppu_pkg::scroll_t v;      // Current address
  ppu_pkg::scroll_t t;      // Temporary address
  ppu_pkg::fine_x_t x;
  logic             toggle; // Shared first/second write latch

  logic coarse_x_step;
  logic data_access;

  // After each attribute fetch, in the visible and prefetch windows
  assign coarse_x_step = cycle[2:0] == 3'd3 &&
                         (cycle < ppu_pkg::HRELOAD_CYCLE ||
                          (cycle >= ppu_pkg::SPRITE_FETCH_END && cycle < ppu_pkg::PREFETCH_END));

  assign data_access = (read || write) && ain == ppu_pkg::REG_DATA;

  always_ff @(posedge clk) begin
    if (reset) begin
      v      <= '0;
      t      <= '0;
      x      <= '0;
      toggle <= 1'b0;
    end else begin
      if (rendering) begin
        if (coarse_x_step) begin
          v[4:0] <= v[4:0] + 5'd1;
          v[10]  <= v[10] ^ (v[4:0] == 5'd31); // Wrap into next nametable
        end
        if (cycle == ppu_pkg::VINC_CYCLE) begin
          v[14:12] <= v[14:12] + 3'd1;
          if (v[14:12] == 3'd7) begin
            if (v[9:5] == 5'd29) begin // Last tile row
              v[9:5] <= '0;
              v[11]  <= !v[11];
            end else begin
              v[9:5] <= v[9:5] + 5'd1;
            end
          end
        end
        if (cycle == ppu_pkg::HRELOAD_CYCLE) begin
          v[10]  <= t[10];
          v[4:0] <= t[4:0];
        end
        if (cycle == ppu_pkg::VRELOAD_CYCLE && pre_render)
          v <= t;
      end

      if (write && ain == ppu_pkg::REG_CTRL) begin
        t[11:10] <= din[1:0]; // Nametable select
      end else if (write && ain == ppu_pkg::REG_SCROLL) begin
        if (!toggle) begin
          t[4:0] <= din[7:3];
          x      <= din[2:0];
        end else begin
          t[9:5]   <= din[7:3];
          t[14:12] <= din[2:0];
        end
        toggle <= !toggle;
      end else if (write && ain == ppu_pkg::REG_ADDR) begin
        if (!toggle) begin
          t[13:8] <= din[5:0];
          t[14]   <= 1'b0;
        end else begin
          t[7:0] <= din;
          v      <= {t[14:8], din}; // Second write commits
        end
        toggle <= !toggle;
      end else if (read && ain == ppu_pkg::REG_STATUS) begin
        toggle <= 1'b0;
      end else if (data_access && !rendering) begin
        v <= v + (addr_inc32 ? 15'd32 : 15'd1);
      end
    end
  end

  assign vaddr  = v;
  assign fine_x = x;

endmodule

// File: logic/frame_timing.sv
// ******************************
// Frame timing generator
// 341 cycles by 262 lines, with line and vblank events
// ******************************
module frame_timing (
  input  logic            clk,
  input  logic            reset,
  input  logic            rendering,
  output ppu_pkg::cycle_t cycle,
  output ppu_pkg::cycle_t scanline,
  output logic            in_vblank,
  output logic            pre_render,
  output logic            end_of_line,
  output logic            last_group,
  output logic            entering_vblank,
  output logic            exiting_vblank
);

  logic odd_frame;  // Every second frame
  logic short_line; // Pre-render line drops its last cycle

  // Group of cycles 336..343
  assign last_group = cycle[8:3] == ppu_pkg::PREFETCH_END[8:3];

  assign pre_render = scanline == ppu_pkg::PRE_RENDER_LINE;
  assign short_line = pre_render && odd_frame && rendering;

  // Cycle 340, or 339 when shortened
  assign end_of_line = last_group && cycle[2:0] == (short_line ? 3'd3 : 3'd4);

  assign entering_vblank = end_of_line && scanline == ppu_pkg::POST_LINE;
  assign exiting_vblank  = end_of_line && scanline == ppu_pkg::VBLANK_LAST_LINE;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle     <= '0;
      in_vblank <= 1'b1;
    end else begin
      cycle <= end_of_line ? '0 : cycle + 9'd1;
      if (entering_vblank)
        in_vblank <= 1'b1;
      else if (exiting_vblank)
        in_vblank <= 1'b0;
    end
  end

  // Line counter wraps from 260 to -1
  always_ff @(posedge clk) begin
    if (reset) begin
      scanline  <= '0;
      odd_frame <= 1'b0;
    end else if (end_of_line) begin
      if (exiting_vblank) begin
        scanline  <= ppu_pkg::PRE_RENDER_LINE;
        odd_frame <= !odd_frame;
      end else begin
        scanline <= scanline + 9'd1;
      end
    end
  end

endmodule

// File: logic/ppu_pkg.sv
// ******************************
// PPU shared definitions
// Vector types, register indices and frame timing constants
// ******************************
package ppu_pkg;

  typedef logic [7:0]  byte_t;      // CPU or VRAM data byte
  typedef logic [2:0]  reg_addr_t;  // CPU register index
  typedef logic [8:0]  cycle_t;     // Cycle or scanline count
  typedef logic [14:0] scroll_t;    // Fine Y, nametable, coarse Y, coarse X
  typedef logic [13:0] vram_addr_t; // VRAM bus address
  typedef logic [2:0]  fine_x_t;    // Fine X scroll
  typedef logic [4:0]  pal_addr_t;  // Palette index
  typedef logic [5:0]  color_t;     // Output colour

  // CPU register map
  localparam reg_addr_t REG_CTRL   = 3'd0;
  localparam reg_addr_t REG_MASK   = 3'd1;
  localparam reg_addr_t REG_STATUS = 3'd2;
  localparam reg_addr_t REG_SCROLL = 3'd5;
  localparam reg_addr_t REG_ADDR   = 3'd6;
  localparam reg_addr_t REG_DATA   = 3'd7;

  // Lines of the frame
  localparam cycle_t LAST_VISIBLE_LINE = 9'd239;
  localparam cycle_t POST_LINE         = 9'd240; // Idle line before vblank
  localparam cycle_t VBLANK_LAST_LINE  = 9'd260;
  localparam cycle_t PRE_RENDER_LINE   = '1;     // Line -1

  // Cycles within a line
  localparam cycle_t HRELOAD_CYCLE    = 9'd256;
  localparam cycle_t VINC_CYCLE       = 9'd251;
  localparam cycle_t VRELOAD_CYCLE    = 9'd304;
  localparam cycle_t SPRITE_FETCH_END = 9'd320; // Prefetch of next line starts here
  localparam cycle_t PREFETCH_END     = 9'd336;

endpackage
